// ==== build.f ====
hw/atm_pkg.sv
hw/atm_session_fsm.sv
hw/atm_account_bank.sv
hw/atm_status_outputs.sv
hw/atm_top.sv
testbench/atm_checker.sv
testbench/atm_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := atm_tb
FILELIST   := build.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert
PASS_MSG   := Finished with no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# the run passes only if the pass line shows up in the output
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== testbench/atm_tb.sv ====
`timescale 1ns/1ps

module atm_tb;

    import atm_pkg::*;

    localparam int          NUM_TESTS       = 6;
    localparam int          CYCLES_PER_TEST = 200;
    localparam int          FLAG_LIMIT      = 20;   // cycles allowed for one flag
    localparam atm_opcode_e OP_NONE         = atm_opcode_e'(3'd7);
    localparam logic [2:0]  F_FINISHED      = 3'd0;
    localparam logic [2:0]  F_BALANCE       = 3'd1;
    localparam logic [2:0]  F_WITHDREW      = 3'd2;
    localparam logic [2:0]  F_DEPOSITED     = 3'd3;
    localparam logic [2:0]  F_PIN           = 3'd4;

    logic                clk;
    logic                reset;
    logic                card_in;
    logic [ACCOUNT_W-1:0] card_account;
    logic                pin_entered;
    logic [PIN_W-1:0]    password;
    atm_opcode_e         opcode;
    logic [AMOUNT_W-1:0] withdraw_amount;
    logic                money_counting;
    logic [AMOUNT_W-1:0] deposit_amount;
    logic [PIN_W-1:0]    new_pin;
    logic                another_transaction_bit;
    logic                atm_usage_finished;
    logic                balance_shown;
    logic [AMOUNT_W-1:0] shown_balance;
    logic                withdrew_successfully;
    logic                deposited_successfully;
    logic                pin_changed_successfully;
    logic [4:0]          flags;
    logic                flag_seen;
    int                  pulse_count [5] = '{default: 0};
    int                  mark [5];
    int                  errors = 0;
    int                  test_errors;
    int                  tests_run = 0;
    int                  failed_tests = 0;
    string               test_name;

    // expected account table
    logic [ACCOUNT_W-1:0] model_account [4] = '{16'd50602, 16'd28764, 16'd12825, 16'd34345};
    logic [PIN_W-1:0]     model_pin [4]     = '{14'd8030, 14'd1215, 14'd1234, 14'd3333};
    logic [AMOUNT_W-1:0]  model_balance [4] = '{32'd5000, 32'd8000, 32'd7500, 32'd3000};

    atm_top i_atm_top (.*);

    assign flags = {pin_changed_successfully, deposited_successfully,
                    withdrew_successfully, balance_shown, atm_usage_finished};

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        for (int i = 0; i < 5; i++) begin
            if (flags[i])
                pulse_count[i] <= pulse_count[i] + 1;
        end
    end

    function automatic string flag_name(input logic [2:0] which);
        case (which)
            F_FINISHED:  return "atm_usage_finished";
            F_BALANCE:   return "balance_shown";
            F_WITHDREW:  return "withdrew_successfully";
            F_DEPOSITED: return "deposited_successfully";
            default:     return "pin_changed_successfully";
        endcase
    endfunction

    task automatic check_bit(input string what, input logic expected, input logic actual);
        if (actual !== expected) begin
            errors++;
            $display("ERR %s %s: expected %0b, actual %0b", test_name, what, expected, actual);
        end
    endtask

    task automatic check_amount(input string what, input logic [AMOUNT_W-1:0] expected,
                                input logic [AMOUNT_W-1:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("ERR %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
        end
    endtask

    task automatic wait_flag(input logic [2:0] which, input logic must);
        flag_seen = 1'b0;
        for (int n = 0; n < FLAG_LIMIT && !flag_seen; n++) begin
            @(posedge clk);
            flag_seen = flags[which];
        end
        if (must && !flag_seen) begin
            errors++;
            $display("%s: %s did not pulse within %0d cycles",
                     test_name, flag_name(which), FLAG_LIMIT);
        end
    endtask

    task automatic check_quiet(input logic [2:0] except);
        @(posedge clk);   // let the last pulse reach the counters
        for (int i = 0; i < 5; i++) begin
            if (i != int'(except))
                check_bit({flag_name(3'(i)), " pulsed"}, 1'b0, pulse_count[i] != mark[i]);
        end
    endtask

    task automatic start_session(input logic [ACCOUNT_W-1:0] account);
        @(posedge clk);
        card_account <= account;
        card_in      <= 1'b1;
        @(posedge clk);
        card_in      <= 1'b0;
    endtask

    task automatic enter_pin(input logic [PIN_W-1:0] pin);
        @(posedge clk);
        password    <= pin;
        pin_entered <= 1'b1;
        @(posedge clk);
        pin_entered <= 1'b0;
    endtask

    task automatic open_session(input int idx);
        start_session(model_account[idx]);
        enter_pin(model_pin[idx]);
    endtask

    task automatic choose(input atm_opcode_e op, input logic more);
        @(posedge clk);
        opcode                  <= op;
        another_transaction_bit <= more;
        @(posedge clk);
        opcode                  <= OP_NONE;
    endtask

    task automatic show_balance(input int idx, input logic more);
        choose(op_balance, more);
        wait_flag(F_BALANCE, 1'b1);
        if (flag_seen)
            check_amount("shown_balance", model_balance[idx], shown_balance);
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = errors;
        mark        = pulse_count;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == test_errors) begin
            $display("%s: done, all checks match", test_name);
        end else begin
            failed_tests++;
            $display("%s: done, %0d error(s)", test_name, errors - test_errors);
        end
    endtask

    task automatic test_unknown_card();
        begin_test("unknown_card");
        start_session(16'd11111);
        wait_flag(F_FINISHED, 1'b1);
        check_quiet(F_FINISHED);
        end_test();
    endtask

    task automatic test_pin_tries();
        begin_test("pin_tries");
        start_session(model_account[2]);
        repeat (3)
            enter_pin(14'd1);
        wait_flag(F_FINISHED, 1'b1);
        check_quiet(F_FINISHED);
        start_session(model_account[2]);
        enter_pin(14'd1);
        enter_pin(model_pin[2]);
        show_balance(2, 1'b0);
        wait_flag(F_FINISHED, 1'b1);
        end_test();
    endtask

    task automatic test_withdraw();
        begin_test("withdraw");
        open_session(0);
        withdraw_amount <= 32'd1000;
        choose(op_withdraw, 1'b1);
        wait_flag(F_WITHDREW, 1'b1);
        model_balance[0] = model_balance[0] - 32'd1000;
        show_balance(0, 1'b0);
        wait_flag(F_FINISHED, 1'b1);
        mark = pulse_count;
        open_session(0);
        withdraw_amount <= 32'd9000;   // more than the balance
        choose(op_withdraw, 1'b0);
        wait_flag(F_FINISHED, 1'b1);
        @(posedge clk);
        check_bit("withdrew_successfully pulsed", 1'b0,
                  pulse_count[F_WITHDREW] != mark[F_WITHDREW]);
        open_session(0);
        show_balance(0, 1'b0);
        wait_flag(F_FINISHED, 1'b1);
        end_test();
    endtask

    task automatic test_deposit();
        begin_test("deposit");
        open_session(1);
        deposit_amount <= 32'd250;
        choose(op_deposit, 1'b1);
        repeat (3) @(posedge clk);
        money_counting <= 1'b1;
        @(posedge clk);
        money_counting <= 1'b0;
        wait_flag(F_DEPOSITED, 1'b1);
        model_balance[1] = model_balance[1] + 32'd250;
        show_balance(1, 1'b0);
        wait_flag(F_FINISHED, 1'b1);
        end_test();
    endtask

    task automatic test_change_pin();
        begin_test("change_pin");
        open_session(3);
        new_pin <= 14'd4321;
        choose(op_change_pin, 1'b0);
        wait_flag(F_PIN, 1'b1);
        wait_flag(F_FINISHED, 1'b1);
        start_session(model_account[3]);
        enter_pin(model_pin[3]);
        model_pin[3] = 14'd4321;
        // menu must stay closed after the old pin
        choose(op_balance, 1'b0);
        wait_flag(F_BALANCE, 1'b0);
        check_bit("balance_shown after old pin", 1'b0, flag_seen);
        enter_pin(model_pin[3]);
        show_balance(3, 1'b0);
        wait_flag(F_FINISHED, 1'b1);
        end_test();
    endtask

    task automatic test_another();
        begin_test("another");
        open_session(2);
        show_balance(2, 1'b1);
        show_balance(2, 1'b1);
        choose(op_eject, 1'b0);
        wait_flag(F_FINISHED, 1'b1);
        end_test();
    endtask

    initial begin
        reset                   = 1'b0;
        card_in                 = 1'b0;
        card_account            = '0;
        pin_entered             = 1'b0;
        password                = '0;
        opcode                  = OP_NONE;
        withdraw_amount         = '0;
        money_counting          = 1'b0;
        deposit_amount          = '0;
        new_pin                 = '0;
        another_transaction_bit = 1'b0;
        repeat (8) @(posedge clk);
        reset <= 1'b1;
        repeat (2) @(posedge clk);
        test_unknown_card();
        test_pin_tries();
        test_withdraw();
        test_deposit();
        test_change_pin();
        test_another();
        errors += i_atm_top.i_atm_checker.assert_failures;
        $display("%0d tests, %0d failed, %0d errors", tests_run, failed_tests, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        repeat (8 + NUM_TESTS * CYCLES_PER_TEST) @(posedge clk);
        $display("watchdog: tests still running after %0d cycles",
                 8 + NUM_TESTS * CYCLES_PER_TEST);
        $display("Finished with errors");
        $finish;
    end

endmodule

// ==== testbench/atm_checker.sv ====
`timescale 1ns/1ps

module atm_checker (
    input logic clk,
    input logic reset,
    input logic atm_usage_finished,
    input logic balance_shown,
    input logic withdrew_successfully,
    input logic deposited_successfully,
    input logic pin_changed_successfully
);

    logic [4:0] flags;
    int         assert_failures = 0;

    assign flags = {pin_changed_successfully, deposited_successfully,
                    withdrew_successfully, balance_shown, atm_usage_finished};

    flags_low_after_reset: assert property (
        @(posedge clk) $rose(reset) |-> (flags == 5'b0)
    ) else begin
        assert_failures++;
        $error("status flag high in the first cycle after reset release");
    end

    one_flag_at_a_time: assert property (
        @(posedge clk) disable iff (!reset) $onehot0(flags)
    ) else begin
        assert_failures++;
        $error("more than one status flag high at once");
    end

    // eject lasts one cycle, so does its flag
    finished_single_pulse: assert property (
        @(posedge clk) disable iff (!reset) atm_usage_finished |=> !atm_usage_finished
    ) else begin
        assert_failures++;
        $error("atm_usage_finished high for two cycles in a row");
    end

endmodule

bind atm_top atm_checker i_atm_checker (
    .clk                      (clk),
    .reset                    (reset),
    .atm_usage_finished       (atm_usage_finished),
    .balance_shown            (balance_shown),
    .withdrew_successfully    (withdrew_successfully),
    .deposited_successfully   (deposited_successfully),
    .pin_changed_successfully (pin_changed_successfully)
);

// ==== hw/atm_top.sv ====
`timescale 1ns/1ps

module atm_top #(
    parameter int NUM_ACCOUNTS = 4
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            card_in,
    input  logic [atm_pkg::ACCOUNT_W-1:0]   card_account,
    input  logic                            pin_entered,
    input  logic [atm_pkg::PIN_W-1:0]       password,
    input  atm_pkg::atm_opcode_e            opcode,
    input  logic [atm_pkg::AMOUNT_W-1:0]    withdraw_amount,
    input  logic                            money_counting,
    input  logic [atm_pkg::AMOUNT_W-1:0]    deposit_amount,
    input  logic [atm_pkg::PIN_W-1:0]       new_pin,
    input  logic                            another_transaction_bit,
    output logic                            atm_usage_finished,
    output logic                            balance_shown,
    output logic [atm_pkg::AMOUNT_W-1:0]    shown_balance,
    output logic                            withdrew_successfully,
    output logic                            deposited_successfully,
    output logic                            pin_changed_successfully
);

    import atm_pkg::*;

    session_state_e      state;
    logic                select_account;
    logic                debit_en;
    logic                credit_en;
    logic                pin_write_en;
    logic                account_found;
    logic [PIN_W-1:0]    current_pin;
    logic [AMOUNT_W-1:0] current_balance;

    // decode
    atm_session_fsm i_atm_session_fsm (
        .clk                     (clk),
        .reset                   (reset),
        .card_in                 (card_in),
        .pin_entered             (pin_entered),
        .password                (password),
        .opcode                  (opcode),
        .withdraw_amount         (withdraw_amount),
        .money_counting          (money_counting),
        .another_transaction_bit (another_transaction_bit),
        .account_found           (account_found),
        .current_pin             (current_pin),
        .current_balance         (current_balance),
        .state                   (state),
        .select_account          (select_account),
        .debit_en                (debit_en),
        .credit_en               (credit_en),
        .pin_write_en            (pin_write_en)
    );

    // execute
    atm_account_bank #(
        .NUM_ACCOUNTS (NUM_ACCOUNTS)
    ) i_atm_account_bank (
        .clk             (clk),
        .reset           (reset),
        .card_account    (card_account),
        .select_account  (select_account),
        .debit_en        (debit_en),
        .credit_en       (credit_en),
        .pin_write_en    (pin_write_en),
        .withdraw_amount (withdraw_amount),
        .deposit_amount  (deposit_amount),
        .new_pin         (new_pin),
        .account_found   (account_found),
        .current_pin     (current_pin),
        .current_balance (current_balance)
    );

    // result
    atm_status_outputs i_atm_status_outputs (
        .clk                      (clk),
        .reset                    (reset),
        .state                    (state),
        .current_balance          (current_balance),
        .atm_usage_finished       (atm_usage_finished),
        .balance_shown            (balance_shown),
        .shown_balance            (shown_balance),
        .withdrew_successfully    (withdrew_successfully),
        .deposited_successfully   (deposited_successfully),
        .pin_changed_successfully (pin_changed_successfully)
    );

endmodule

// ==== hw/atm_status_outputs.sv ====
`timescale 1ns/1ps

module atm_status_outputs (
    input  logic                            clk,
    input  logic                            reset,
    input  atm_pkg::session_state_e         state,
    input  logic [atm_pkg::AMOUNT_W-1:0]    current_balance,
    output logic                            atm_usage_finished,
    output logic                            balance_shown,
    output logic [atm_pkg::AMOUNT_W-1:0]    shown_balance,
    output logic                            withdrew_successfully,
    output logic                            deposited_successfully,
    output logic                            pin_changed_successfully
);

    import atm_pkg::*;

    // every flag is high for the one cycle after its state
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            atm_usage_finished       <= 1'b0;
            balance_shown            <= 1'b0;
            withdrew_successfully    <= 1'b0;
            deposited_successfully   <= 1'b0;
            pin_changed_successfully <= 1'b0;
        end else begin
            atm_usage_finished       <= (state == st_eject);
            balance_shown            <= (state == st_balance);
            withdrew_successfully    <= (state == st_confirm_withdraw);
            deposited_successfully   <= (state == st_confirm_deposit);
            pin_changed_successfully <= (state == st_change_pin);
        end
    end

    // display holds until the next balance request
    always_ff @(posedge clk or negedge reset) begin
        if (!reset)
            shown_balance <= '0;
        else if (state == st_balance)
            shown_balance <= current_balance;
    end

endmodule

// ==== hw/atm_account_bank.sv ====
`timescale 1ns/1ps

module atm_account_bank #(
    parameter int NUM_ACCOUNTS = 4
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic [atm_pkg::ACCOUNT_W-1:0]   card_account,
    input  logic                            select_account,
    input  logic                            debit_en,
    input  logic                            credit_en,
    input  logic                            pin_write_en,
    input  logic [atm_pkg::AMOUNT_W-1:0]    withdraw_amount,
    input  logic [atm_pkg::AMOUNT_W-1:0]    deposit_amount,
    input  logic [atm_pkg::PIN_W-1:0]       new_pin,
    output logic                            account_found,
    output logic [atm_pkg::PIN_W-1:0]       current_pin,
    output logic [atm_pkg::AMOUNT_W-1:0]    current_balance
);

    import atm_pkg::*;

    localparam int IDX_W = (NUM_ACCOUNTS > 1) ? $clog2(NUM_ACCOUNTS) : 1;

    logic [PIN_W-1:0]    pin_table     [NUM_ACCOUNTS];
    logic [AMOUNT_W-1:0] balance_table [NUM_ACCOUNTS];
    logic [IDX_W-1:0]    found_idx;
    logic [IDX_W-1:0]    sel_idx;   // account of the running session

    // match card number against the fixed account numbers
    always_comb begin
        account_found = 1'b0;
        found_idx     = '0;
        for (int i = 0; i < NUM_ACCOUNTS; i++) begin
            if (INIT_ACCOUNT_NO[i] == card_account) begin
                account_found = 1'b1;
                found_idx     = IDX_W'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset)
            sel_idx <= '0;
        else if (select_account)
            sel_idx <= found_idx;
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < NUM_ACCOUNTS; i++) begin
                pin_table[i]     <= INIT_PIN[i];
                balance_table[i] <= INIT_BALANCE[i];
            end
        end else begin
            if (debit_en)
                balance_table[sel_idx] <= balance_table[sel_idx] - withdraw_amount;
            else if (credit_en)
                balance_table[sel_idx] <= balance_table[sel_idx] + deposit_amount;
            if (pin_write_en)
                pin_table[sel_idx] <= new_pin;
        end
    end

    assign current_pin     = pin_table[sel_idx];
    assign current_balance = balance_table[sel_idx];

endmodule

// ==== hw/atm_session_fsm.sv ====
`timescale 1ns/1ps

module atm_session_fsm (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            card_in,
    input  logic                            pin_entered,
    input  logic [atm_pkg::PIN_W-1:0]       password,
    input  atm_pkg::atm_opcode_e            opcode,
    input  logic [atm_pkg::AMOUNT_W-1:0]    withdraw_amount,
    input  logic                            money_counting,
    input  logic                            another_transaction_bit,
    input  logic                            account_found,
    input  logic [atm_pkg::PIN_W-1:0]       current_pin,
    input  logic [atm_pkg::AMOUNT_W-1:0]    current_balance,
    output atm_pkg::session_state_e         state,
    output logic                            select_account,
    output logic                            debit_en,
    output logic                            credit_en,
    output logic                            pin_write_en
);

    import atm_pkg::*;

    localparam int TRY_W = $clog2(MAX_PIN_TRIES + 1);

    session_state_e next_state;
    logic [TRY_W-1:0] pin_tries;   // wrong pins this session
    logic pin_miss;
    logic last_try;

    assign pin_miss = (state == st_pin) && pin_entered && (password != current_pin);
    assign last_try = (pin_tries == TRY_W'(MAX_PIN_TRIES - 1));

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state     <= st_idle;
            pin_tries <= '0;
        end else begin
            state <= next_state;
            if (state == st_idle)
                pin_tries <= '0;
            else if (pin_miss)
                pin_tries <= pin_tries + 1'b1;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (card_in)
                    next_state = st_lookup;
            end
            st_lookup: begin
                next_state = account_found ? st_pin : st_eject;
            end
            st_pin: begin
                if (pin_entered) begin
                    if (password == current_pin)
                        next_state = st_home;
                    else if (last_try)
                        next_state = st_eject;   // out of chances
                end
            end
            st_home: begin
                // opcode level is sampled every cycle
                case (opcode)
                    op_eject:      next_state = st_eject;
                    op_balance:    next_state = st_balance;
                    op_withdraw:   next_state = st_withdraw;
                    op_deposit:    next_state = st_deposit;
                    op_change_pin: next_state = st_change_pin;
                    default:       next_state = st_home;
                endcase
            end
            st_withdraw: begin
                if (withdraw_amount > current_balance)
                    next_state = st_eject;   // refused
                else
                    next_state = st_confirm_withdraw;
            end
            st_deposit: begin
                if (money_counting)
                    next_state = st_confirm_deposit;
            end
            st_balance,
            st_confirm_withdraw,
            st_confirm_deposit,
            st_change_pin: begin
                next_state = st_another;
            end
            st_another: begin
                next_state = another_transaction_bit ? st_home : st_eject;
            end
            st_eject: begin
                next_state = st_idle;
            end
            default: begin
                next_state = st_idle;
            end
        endcase
    end

    // one-cycle commands to the bank
    assign select_account = (state == st_lookup) && account_found;
    assign debit_en       = (state == st_confirm_withdraw);
    assign credit_en      = (state == st_confirm_deposit);
    assign pin_write_en   = (state == st_change_pin);

endmodule

// ==== hw/atm_pkg.sv ====
package atm_pkg;

    localparam int ACCOUNT_W     = 16;
    localparam int PIN_W         = 14;
    localparam int AMOUNT_W      = 32;
    localparam int MAX_ACCOUNTS  = 4;
    localparam int MAX_PIN_TRIES = 3;

    // built-in account table, row i is one customer
    localparam logic [ACCOUNT_W-1:0] INIT_ACCOUNT_NO [MAX_ACCOUNTS] =
        '{16'd50602, 16'd28764, 16'd12825, 16'd34345};
    localparam logic [PIN_W-1:0] INIT_PIN [MAX_ACCOUNTS] =
        '{14'd8030, 14'd1215, 14'd1234, 14'd3333};
    localparam logic [AMOUNT_W-1:0] INIT_BALANCE [MAX_ACCOUNTS] =
        '{32'd5000, 32'd8000, 32'd7500, 32'd3000};

    // 4 was transfer, retired; 4, 6 and 7 mean no choice yet
    typedef enum logic [2:0] {
        op_eject      = 3'd0,
        op_balance    = 3'd1,
        op_withdraw   = 3'd2,
        op_deposit    = 3'd3,
        op_change_pin = 3'd5
    } atm_opcode_e;

    typedef enum logic [3:0] {
        st_idle,
        st_lookup,
        st_pin,
        st_home,
        st_balance,
        st_withdraw,
        st_confirm_withdraw,
        st_deposit,
        st_confirm_deposit,
        st_change_pin,
        st_another,
        st_eject
    } session_state_e;

endpackage
